// ==== rtl/lsq_cfg_pkg.sv ====
// widths and default sizes for the load-store queue and its memory stand-in
// addresses are word addresses and there are no byte enables
package lsq_cfg_pkg;

	// ********************
	// datapath widths
	// ********************
	localparam int ADDR_W    = 8;
	localparam int DATA_W    = 32;
	localparam int ROB_IDX_W = 5;
	localparam int TAG_W     = 6;

	// ********************
	// default sizes
	// ********************
	// depths must be powers of two
	localparam int SQ_DEPTH_DEF    = 8;
	localparam int LQ_DEPTH_DEF    = 4;
	localparam int MISSQ_DEPTH_DEF = 2;
	// at least 2
	localparam int MISS_LAT_DEF    = 6;

endpackage

// ==== rtl/lsq_types_pkg.sv ====
// encodings shared by the result port and the miss unit
package lsq_types_pkg;

	// where a completed load took its data from
	typedef enum logic [1:0] {
		SRC_FWD  = 2'd0,
		SRC_HIT  = 2'd1,
		SRC_FILL = 2'd2
	} ld_src_e;

	// miss unit FSM
	typedef enum logic [1:0] {
		MS_IDLE = 2'd0,
		MS_WAIT = 2'd1,
		MS_FILL = 2'd2
	} miss_state_e;

endpackage

// ==== rtl/store_queue.sv ====
`timescale 1ns/1ps
// stores in program order between dispatch and retire; SQ_DEPTH must be a power of two
// ld_pos_i has no wrap bit, so a full queue with head at ld_pos_i counts as all older
module store_queue #(
	parameter int SQ_DEPTH = 8,
	localparam int SQ_IDX_W = $clog2(SQ_DEPTH)
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            alloc_i,
	input  logic                            exec_i,
	input  logic [SQ_IDX_W-1:0]             exec_idx_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0]  exec_addr_i,
	input  logic [lsq_cfg_pkg::DATA_W-1:0]  exec_data_i,
	input  logic                            retire_i,
	input  logic [SQ_IDX_W-1:0]             ld_pos_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0]  ld_addr_i,
	output logic [SQ_IDX_W-1:0]             tail_o,
	output logic                            full_o,
	output logic                            issue_ok_o,
	output logic                            fwd_hit_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0]  fwd_data_o,
	output logic [lsq_cfg_pkg::ADDR_W-1:0]  head_addr_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0]  head_data_o
);

	// pointers carry a wrap bit on top of the slot index
	logic [SQ_IDX_W:0]                   head_q;
	logic [SQ_IDX_W:0]                   tail_q;
	logic [SQ_IDX_W-1:0]                 head_idx;
	logic [SQ_IDX_W-1:0]                 tail_idx;
	logic [lsq_cfg_pkg::ADDR_W-1:0]      st_addr_r [SQ_DEPTH];
	logic [lsq_cfg_pkg::DATA_W-1:0]      st_data_r [SQ_DEPTH];
	logic [SQ_DEPTH-1:0]                 addr_known_r;
	logic                                pos_wrapped;
	logic [SQ_DEPTH-1:0]                 older;
	logic                                fwd_lo_hit;
	logic                                fwd_hi_hit;
	logic [lsq_cfg_pkg::DATA_W-1:0]      fwd_lo_data;
	logic [lsq_cfg_pkg::DATA_W-1:0]      fwd_hi_data;

	assign head_idx = head_q[SQ_IDX_W-1:0];
	assign tail_idx = tail_q[SQ_IDX_W-1:0];
	assign full_o   = (head_idx == tail_idx) && (head_q[SQ_IDX_W] != tail_q[SQ_IDX_W]);
	assign tail_o   = tail_idx;

	// retire port reads the oldest store
	assign head_addr_o = st_addr_r[head_idx];
	assign head_data_o = st_data_r[head_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (alloc_i)
				tail_q <= tail_q + 1'b1;
			if (retire_i)
				head_q <= head_q + 1'b1;
		end
	end

	// address known from execute until retire
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_known_r <= '0;
		end else begin
			if (exec_i)
				addr_known_r[exec_idx_i] <= 1'b1;
			if (retire_i)
				addr_known_r[head_idx] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (exec_i) begin
			st_addr_r[exec_idx_i] <= exec_addr_i;
			st_data_r[exec_idx_i] <= exec_data_i;
		end
	end

	// ********************
	// age check
	// ********************
	// older stores sit in [head, pos) or wrap around as [head, end) plus [0, pos)
	assign pos_wrapped = (ld_pos_i < head_idx) || (full_o && (ld_pos_i == tail_idx));

	always_comb begin
		for (int i = 0; i < SQ_DEPTH; i++) begin
			if (pos_wrapped)
				older[i] = (SQ_IDX_W'(i) < ld_pos_i) || (SQ_IDX_W'(i) >= head_idx);
			else
				older[i] = (SQ_IDX_W'(i) >= head_idx) && (SQ_IDX_W'(i) < ld_pos_i);
		end
	end

	assign issue_ok_o = &(addr_known_r | ~older);

	// ********************
	// forwarding search
	// ********************
	// ascending scan so the last match in each range is the youngest
	always_comb begin
		fwd_lo_hit  = 1'b0;
		fwd_hi_hit  = 1'b0;
		fwd_lo_data = '0;
		fwd_hi_data = '0;
		for (int i = 0; i < SQ_DEPTH; i++) begin
			if (older[i] && addr_known_r[i] && (st_addr_r[i] == ld_addr_i)) begin
				if (SQ_IDX_W'(i) < ld_pos_i) begin
					fwd_lo_hit  = 1'b1;
					fwd_lo_data = st_data_r[i];
				end else begin
					fwd_hi_hit  = 1'b1;
					fwd_hi_data = st_data_r[i];
				end
			end
		end
	end

	// slots below the position are younger than any above head
	assign fwd_hit_o  = fwd_lo_hit || fwd_hi_hit;
	assign fwd_data_o = fwd_lo_hit ? fwd_lo_data : fwd_hi_data;

endmodule

// ==== rtl/load_queue.sv ====
`timescale 1ns/1ps
// missed loads wait here for a fill and leave strictly in park order
// LQ_DEPTH must be a power of two of at least 2
module load_queue #(
	parameter int LQ_DEPTH = 4,
	localparam int LQ_IDX_W = $clog2(LQ_DEPTH)
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              park_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0]    park_addr_i,
	input  logic [lsq_cfg_pkg::ROB_IDX_W-1:0] park_rob_idx_i,
	input  logic [lsq_cfg_pkg::TAG_W-1:0]     park_tag_i,
	input  logic                              fill_valid_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0]    fill_addr_i,
	input  logic [lsq_cfg_pkg::DATA_W-1:0]    fill_data_i,
	output logic                              full_o,
	output logic                              done_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0]    done_data_o,
	output logic [lsq_cfg_pkg::ROB_IDX_W-1:0] done_rob_idx_o,
	output logic [lsq_cfg_pkg::TAG_W-1:0]     done_tag_o
);

	logic [LQ_IDX_W:0]                       head_q;
	logic [LQ_IDX_W:0]                       tail_q;
	logic [LQ_IDX_W-1:0]                     head_idx;
	logic [LQ_IDX_W-1:0]                     tail_idx;
	logic [lsq_cfg_pkg::ADDR_W-1:0]          addr_r [LQ_DEPTH];
	logic [lsq_cfg_pkg::DATA_W-1:0]          data_r [LQ_DEPTH];
	logic [lsq_cfg_pkg::ROB_IDX_W-1:0]       rob_idx_r [LQ_DEPTH];
	logic [lsq_cfg_pkg::TAG_W-1:0]           tag_r [LQ_DEPTH];
	// waiting for a fill / fill data captured
	logic [LQ_DEPTH-1:0]                     wait_r;
	logic [LQ_DEPTH-1:0]                     rdy_r;
	logic [LQ_DEPTH-1:0]                     fill_match;
	logic                                    not_empty;

	assign head_idx  = head_q[LQ_IDX_W-1:0];
	assign tail_idx  = tail_q[LQ_IDX_W-1:0];
	assign not_empty = (head_q != tail_q);
	assign full_o    = (head_idx == tail_idx) && (head_q[LQ_IDX_W] != tail_q[LQ_IDX_W]);

	// one fill serves every waiting load to that word
	always_comb begin
		for (int k = 0; k < LQ_DEPTH; k++)
			fill_match[k] = fill_valid_i && wait_r[k] && (addr_r[k] == fill_addr_i);
	end

	// head may leave in the cycle its own fill arrives
	assign done_o         = not_empty && (rdy_r[head_idx] || fill_match[head_idx]);
	assign done_data_o    = rdy_r[head_idx] ? data_r[head_idx] : fill_data_i;
	assign done_rob_idx_o = rob_idx_r[head_idx];
	assign done_tag_o     = tag_r[head_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (park_i)
				tail_q <= tail_q + 1'b1;
			if (done_o)
				head_q <= head_q + 1'b1;
		end
	end

	// ********************
	// entry status
	// ********************
	always_ff @(posedge clk) begin
		if (rst) begin
			wait_r <= '0;
			rdy_r  <= '0;
		end else begin
			for (int k = 0; k < LQ_DEPTH; k++) begin
				if (fill_match[k]) begin
					wait_r[k] <= 1'b0;
					rdy_r[k]  <= 1'b1;
				end
			end
			if (done_o) begin
				wait_r[head_idx] <= 1'b0;
				rdy_r[head_idx]  <= 1'b0;
			end
			if (park_i) begin
				wait_r[tail_idx] <= 1'b1;
				rdy_r[tail_idx]  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < LQ_DEPTH; k++) begin
			if (fill_match[k])
				data_r[k] <= fill_data_i;
		end
		if (park_i) begin
			addr_r[tail_idx]    <= park_addr_i;
			rob_idx_r[tail_idx] <= park_rob_idx_i;
			tag_r[tail_idx]     <= park_tag_i;
		end
	end

endmodule

// ==== rtl/miss_unit.sv ====
`timescale 1ns/1ps
// data memory stand-in; a word is present once filled or written by a retire
// misses are served one at a time and MISS_LAT must be at least 2
module miss_unit #(
	parameter int MISSQ_DEPTH = 2,
	parameter int MISS_LAT = 6,
	localparam int MQ_IDX_W = $clog2(MISSQ_DEPTH),
	localparam int CNT_W = $clog2(MISS_LAT) + 1
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0] lookup_addr_i,
	input  logic                           miss_req_i,
	input  logic                           wr_en_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0] wr_addr_i,
	input  logic [lsq_cfg_pkg::DATA_W-1:0] wr_data_i,
	output logic                           lookup_hit_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0] lookup_data_o,
	output logic                           missq_full_o,
	output logic                           fill_valid_o,
	output logic [lsq_cfg_pkg::ADDR_W-1:0] fill_addr_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0] fill_data_o
);

	localparam int MEM_WORDS = 1 << lsq_cfg_pkg::ADDR_W;

	logic [lsq_cfg_pkg::DATA_W-1:0] mem_r [MEM_WORDS];
	logic [MEM_WORDS-1:0]           written_r;
	logic [MEM_WORDS-1:0]           present_r;
	logic [lsq_cfg_pkg::ADDR_W-1:0] mq_addr_r [MISSQ_DEPTH];
	logic [lsq_cfg_pkg::DATA_W-1:0] mq_data_r [MISSQ_DEPTH];
	logic [MISSQ_DEPTH-1:0]         mq_vld_r;
	logic [MQ_IDX_W:0]              mq_head_q;
	logic [MQ_IDX_W:0]              mq_tail_q;
	logic                           pending;
	logic                           push;
	logic                           pop;
	logic [CNT_W-1:0]               cnt_r;
	logic [lsq_cfg_pkg::DATA_W-1:0] word_rd;
	lsq_types_pkg::miss_state_e     state_r;
	lsq_types_pkg::miss_state_e     state_nxt;

	// unwritten words read as zero
	assign word_rd       = written_r[lookup_addr_i] ? mem_r[lookup_addr_i] : '0;
	assign lookup_data_o = word_rd;
	// a fill in flight counts as a hit for the same word
	assign lookup_hit_o  = present_r[lookup_addr_i] || (fill_valid_o && (fill_addr_o == lookup_addr_i));

	// ********************
	// miss request queue
	// ********************
	always_comb begin
		pending = 1'b0;
		for (int k = 0; k < MISSQ_DEPTH; k++) begin
			if (mq_vld_r[k] && (mq_addr_r[k] == lookup_addr_i))
				pending = 1'b1;
		end
	end

	assign push         = miss_req_i && !pending;
	assign pop          = (state_r == lsq_types_pkg::MS_FILL);
	assign missq_full_o = (mq_head_q[MQ_IDX_W-1:0] == mq_tail_q[MQ_IDX_W-1:0]) &&
		(mq_head_q[MQ_IDX_W] != mq_tail_q[MQ_IDX_W]);
	assign fill_valid_o = pop;
	assign fill_addr_o  = mq_addr_r[mq_head_q[MQ_IDX_W-1:0]];
	assign fill_data_o  = mq_data_r[mq_head_q[MQ_IDX_W-1:0]];

	always_ff @(posedge clk) begin
		if (rst) begin
			mq_head_q <= '0;
			mq_tail_q <= '0;
			mq_vld_r  <= '0;
		end else begin
			if (pop) begin
				mq_head_q                           <= mq_head_q + 1'b1;
				mq_vld_r[mq_head_q[MQ_IDX_W-1:0]]   <= 1'b0;
			end
			if (push) begin
				mq_tail_q                           <= mq_tail_q + 1'b1;
				mq_vld_r[mq_tail_q[MQ_IDX_W-1:0]]   <= 1'b1;
			end
		end
	end

	// request carries a snapshot of the word
	always_ff @(posedge clk) begin
		if (push) begin
			mq_addr_r[mq_tail_q[MQ_IDX_W-1:0]] <= lookup_addr_i;
			mq_data_r[mq_tail_q[MQ_IDX_W-1:0]] <= word_rd;
		end
		if (wr_en_i)
			mem_r[wr_addr_i] <= wr_data_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			written_r <= '0;
			present_r <= '0;
		end else begin
			if (pop)
				present_r[fill_addr_o] <= 1'b1;
			if (wr_en_i) begin
				written_r[wr_addr_i] <= 1'b1;
				present_r[wr_addr_i] <= 1'b1;
			end
		end
	end

	// ********************
	// latency FSM
	// ********************
	always_comb begin
		state_nxt = state_r;
		case (state_r)
			lsq_types_pkg::MS_IDLE:
				if (mq_head_q != mq_tail_q)
					state_nxt = lsq_types_pkg::MS_WAIT;
			lsq_types_pkg::MS_WAIT:
				if (cnt_r == CNT_W'(MISS_LAT - 2))
					state_nxt = lsq_types_pkg::MS_FILL;
			default:
				state_nxt = lsq_types_pkg::MS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= lsq_types_pkg::MS_IDLE;
			cnt_r   <= '0;
		end else begin
			state_r <= state_nxt;
			cnt_r   <= (state_r == lsq_types_pkg::MS_WAIT) ? cnt_r + 1'b1 : '0;
		end
	end

endmodule

// ==== rtl/lsq_top.sv ====
`timescale 1ns/1ps
// load-store queue with memory stand-in; the result port is registered
// forwarded and hit loads answer one cycle after acceptance, misses later
module lsq_top #(
	parameter int SQ_DEPTH = lsq_cfg_pkg::SQ_DEPTH_DEF,
	parameter int LQ_DEPTH = lsq_cfg_pkg::LQ_DEPTH_DEF,
	parameter int MISSQ_DEPTH = lsq_cfg_pkg::MISSQ_DEPTH_DEF,
	parameter int MISS_LAT = lsq_cfg_pkg::MISS_LAT_DEF,
	localparam int SQ_IDX_W = $clog2(SQ_DEPTH)
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              disp_valid_i,
	input  logic                              st_valid_i,
	input  logic [SQ_IDX_W-1:0]               st_idx_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0]    st_addr_i,
	input  logic [lsq_cfg_pkg::DATA_W-1:0]    st_data_i,
	input  logic                              retire_i,
	input  logic                              ld_valid_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0]    ld_addr_i,
	input  logic [SQ_IDX_W-1:0]               ld_sq_pos_i,
	input  logic [lsq_cfg_pkg::ROB_IDX_W-1:0] ld_rob_idx_i,
	input  logic [lsq_cfg_pkg::TAG_W-1:0]     ld_tag_i,
	output logic                              disp_ready_o,
	output logic [SQ_IDX_W-1:0]               disp_idx_o,
	output logic                              ld_ready_o,
	output logic                              res_valid_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0]    res_data_o,
	output logic [lsq_cfg_pkg::ROB_IDX_W-1:0] res_rob_idx_o,
	output logic [lsq_cfg_pkg::TAG_W-1:0]     res_tag_o,
	output lsq_types_pkg::ld_src_e            res_src_o
);

	logic                              sq_full;
	logic                              issue_ok;
	logic                              fwd_hit;
	logic [lsq_cfg_pkg::DATA_W-1:0]    fwd_data;
	logic [lsq_cfg_pkg::ADDR_W-1:0]    head_addr;
	logic [lsq_cfg_pkg::DATA_W-1:0]    head_data;
	logic                              lookup_hit;
	logic [lsq_cfg_pkg::DATA_W-1:0]    lookup_data;
	logic                              missq_full;
	logic                              fill_valid;
	logic [lsq_cfg_pkg::ADDR_W-1:0]    fill_addr;
	logic [lsq_cfg_pkg::DATA_W-1:0]    fill_data;
	logic                              lq_full;
	logic                              lq_done;
	logic [lsq_cfg_pkg::DATA_W-1:0]    done_data;
	logic [lsq_cfg_pkg::ROB_IDX_W-1:0] done_rob_idx;
	logic [lsq_cfg_pkg::TAG_W-1:0]     done_tag;
	logic                              disp_fire;
	logic                              ld_fire;
	logic                              ld_miss;

	// ********************
	// handshakes
	// ********************
	assign disp_ready_o = !sq_full;
	assign disp_fire    = disp_valid_i && disp_ready_o;
	// a completing parked load owns the result port this cycle
	assign ld_ready_o   = issue_ok && !lq_full && !missq_full && !lq_done;
	assign ld_fire      = ld_valid_i && ld_ready_o;
	// forwarding wins over a hit
	assign ld_miss      = ld_fire && !fwd_hit && !lookup_hit;

	store_queue #(.SQ_DEPTH(SQ_DEPTH)) u_sq (
		.clk(clk), .rst(rst), .alloc_i(disp_fire), .exec_i(st_valid_i),
		.exec_idx_i(st_idx_i), .exec_addr_i(st_addr_i), .exec_data_i(st_data_i),
		.retire_i(retire_i), .ld_pos_i(ld_sq_pos_i), .ld_addr_i(ld_addr_i),
		.tail_o(disp_idx_o), .full_o(sq_full), .issue_ok_o(issue_ok), .fwd_hit_o(fwd_hit),
		.fwd_data_o(fwd_data), .head_addr_o(head_addr), .head_data_o(head_data)
	);

	load_queue #(.LQ_DEPTH(LQ_DEPTH)) u_lq (
		.clk(clk), .rst(rst), .park_i(ld_miss), .park_addr_i(ld_addr_i),
		.park_rob_idx_i(ld_rob_idx_i), .park_tag_i(ld_tag_i), .fill_valid_i(fill_valid),
		.fill_addr_i(fill_addr), .fill_data_i(fill_data), .full_o(lq_full), .done_o(lq_done),
		.done_data_o(done_data), .done_rob_idx_o(done_rob_idx), .done_tag_o(done_tag)
	);

	miss_unit #(.MISSQ_DEPTH(MISSQ_DEPTH), .MISS_LAT(MISS_LAT)) u_mu (
		.clk(clk), .rst(rst), .lookup_addr_i(ld_addr_i), .miss_req_i(ld_miss),
		.wr_en_i(retire_i), .wr_addr_i(head_addr), .wr_data_i(head_data),
		.lookup_hit_o(lookup_hit), .lookup_data_o(lookup_data), .missq_full_o(missq_full),
		.fill_valid_o(fill_valid), .fill_addr_o(fill_addr), .fill_data_o(fill_data)
	);

	// ********************
	// result port
	// ********************
	always_ff @(posedge clk) begin
		if (rst)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= lq_done || (ld_fire && !ld_miss);
	end

	always_ff @(posedge clk) begin
		if (lq_done) begin
			res_data_o    <= done_data;
			res_rob_idx_o <= done_rob_idx;
			res_tag_o     <= done_tag;
			res_src_o     <= lsq_types_pkg::SRC_FILL;
		end else begin
			res_data_o    <= fwd_hit ? fwd_data : lookup_data;
			res_rob_idx_o <= ld_rob_idx_i;
			res_tag_o     <= ld_tag_i;
			res_src_o     <= fwd_hit ? lsq_types_pkg::SRC_FWD : lsq_types_pkg::SRC_HIT;
		end
	end

endmodule

// ==== testbench/lsq_checker.sv ====
`timescale 1ns/1ps
// load handshake, store stimulus and miss latency assertions, bound into lsq_top
module lsq_checker #(
	parameter int MISS_LAT = lsq_cfg_pkg::MISS_LAT_DEF
) (
	input logic                       clk,
	input logic                       rst,
	input logic                       ld_valid_i,
	input logic                       ld_ready_i,
	input logic                       st_valid_i,
	input logic                       st_known_i,
	input logic                       retire_i,
	input logic                       head_known_i,
	input lsq_types_pkg::miss_state_e ms_state_i
);

	// an offered load stays up until accepted
	ld_held: assert property (@(posedge clk) disable iff (rst)
		ld_valid_i && !ld_ready_i |=> ld_valid_i)
		else $error("load valid dropped before acceptance");

	// a slot executes once between dispatch and retire
	exec_once: assert property (@(posedge clk) disable iff (rst) st_valid_i |-> !st_known_i)
		else $error("store executed into a slot that already has an address");

	retire_after_exec: assert property (@(posedge clk) disable iff (rst)
		retire_i |-> head_known_i)
		else $error("retire of a head store that has no address");

	// wait phase lasts MISS_LAT - 1 cycles, then the fill cycle
	miss_latency: assert property (@(posedge clk) disable iff (rst)
		$rose(ms_state_i == lsq_types_pkg::MS_WAIT) |->
		##(MISS_LAT - 1) ms_state_i == lsq_types_pkg::MS_FILL)
		else $error("miss fill not at the configured latency");

endmodule

bind lsq_top lsq_checker #(.MISS_LAT(MISS_LAT)) u_checker (
	.clk(clk), .rst(rst), .ld_valid_i(ld_valid_i), .ld_ready_i(ld_ready_o),
	.st_valid_i(st_valid_i), .st_known_i(u_sq.addr_known_r[st_idx_i]), .retire_i(retire_i),
	.head_known_i(u_sq.addr_known_r[u_sq.head_idx]), .ms_state_i(u_mu.state_r)
);

// ==== testbench/lsq_tb.sv ====
`timescale 1ns/1ps
// random traffic checked against a model of store forwarding and memory
// one load is offered at a time and held until accepted; rob indices are never reused in flight
module lsq_tb;

	localparam int SQD = lsq_cfg_pkg::SQ_DEPTH_DEF;
	localparam int SQ_IDX_W = $clog2(SQD);
	localparam int AW = lsq_cfg_pkg::ADDR_W;
	localparam int DW = lsq_cfg_pkg::DATA_W;
	localparam int RW = lsq_cfg_pkg::ROB_IDX_W;
	localparam int TW = lsq_cfg_pkg::TAG_W;
	localparam int MEM_WORDS = 1 << AW;
	localparam int ROBS = 1 << RW;
	localparam int NUM_CYCLES = 1500;
	localparam int PERIOD = 40;
	localparam int WATCHDOG_NS = NUM_CYCLES * (lsq_cfg_pkg::MISS_LAT_DEF + 4) * PERIOD;

	logic clk, rst, disp_valid_i, st_valid_i, retire_i, ld_valid_i;
	logic [SQ_IDX_W-1:0] st_idx_i, ld_sq_pos_i, disp_idx_o;
	logic [AW-1:0] st_addr_i, ld_addr_i;
	logic [DW-1:0] st_data_i, res_data_o;
	logic [RW-1:0] ld_rob_idx_i, res_rob_idx_o;
	logic [TW-1:0] ld_tag_i, res_tag_o;
	logic disp_ready_o, ld_ready_o, res_valid_o;
	lsq_types_pkg::ld_src_e res_src_o;

	// ********************
	// reference model state
	// ********************
	// store pointers count without wrapping
	int m_head, m_tail;
	logic [AW-1:0] m_addr [SQD];
	logic [DW-1:0] m_data [SQD];
	bit m_exec [SQD];
	bit [DW-1:0] mem_m [MEM_WORDS];
	bit present_m [MEM_WORDS];
	bit touched_m [MEM_WORDS];
	// expected results by rob index
	bit exp_vld [ROBS];
	bit exp_either [ROBS];
	logic [DW-1:0] exp_data [ROBS];
	logic [TW-1:0] exp_tag [ROBS];
	lsq_types_pkg::ld_src_e exp_src [ROBS];
	int exp_cyc [ROBS];
	bit ld_pend;
	int ld_pos_abs, next_rob, outstanding, cyc, last_fill_cyc, seed;
	int errors, err_at_start, tests_run, tests_failed;
	string test_name;

	lsq_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	task automatic check_data(input string what, input logic [DW-1:0] exp, input logic [DW-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_tag(input string what, input logic [TW-1:0] exp,
		input logic [TW-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_idx(input string what, input logic [SQ_IDX_W-1:0] exp,
		input logic [SQ_IDX_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_src(input string what, input lsq_types_pkg::ld_src_e exp,
		input lsq_types_pkg::ld_src_e act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %s, actual %s", test_name, what, exp.name(),
				act.name());
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR in %s: %s", test_name, msg);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_at_start = errors;
	endtask

	task automatic finish_test;
		tests_run++;
		if (errors != err_at_start)
			tests_failed++;
		$display("test %s %s", test_name, (errors == err_at_start) ? "ok" : "had errors");
	endtask

	// ********************
	// result port
	// ********************
	task automatic collect_result;
		int r;
		lsq_types_pkg::ld_src_e want;
		if (!res_valid_o)
			return;
		r = int'(res_rob_idx_o);
		if (!exp_vld[r]) begin
			report_error($sformatf("result for rob index %0d with no load outstanding", r));
			return;
		end
		want = exp_src[r];
		if (exp_either[r] && res_src_o == lsq_types_pkg::SRC_HIT)
			want = lsq_types_pkg::SRC_HIT;
		check_data("res_data", exp_data[r], res_data_o);
		check_tag("res_tag", exp_tag[r], res_tag_o);
		check_src("res_src", want, res_src_o);
		if (res_src_o == lsq_types_pkg::SRC_FILL) begin
			// a load merged into a pending miss may finish sooner
			if (!exp_either[r] && cyc - exp_cyc[r] < lsq_cfg_pkg::MISS_LAT_DEF)
				report_error("fill result sooner than the miss latency");
			if (exp_cyc[r] <= last_fill_cyc)
				report_error("parked loads completed out of load queue order");
			last_fill_cyc = exp_cyc[r];
		end else if (cyc != exp_cyc[r] + 1) begin
			report_error("forwarded or hit result not one cycle after acceptance");
		end
		exp_vld[r] = 1'b0;
		outstanding--;
	endtask

	// expected data is fixed at acceptance, before this cycle's retire
	task automatic accept_load;
		int r;
		int slot;
		bit ok;
		bit fwd;
		logic [DW-1:0] d;
		ok = 1'b1;
		fwd = 1'b0;
		d = '0;
		for (int j = 0; j < ld_pos_abs - m_head; j++) begin
			slot = (m_head + j) % SQD;
			if (!m_exec[slot]) begin
				ok = 1'b0;
			end else if (m_addr[slot] == ld_addr_i) begin
				fwd = 1'b1;
				d = m_data[slot];
			end
		end
		if (!ok)
			report_error("load accepted while an older store had no address");
		r = int'(ld_rob_idx_i);
		exp_vld[r] = 1'b1;
		exp_tag[r] = ld_tag_i;
		exp_cyc[r] = cyc;
		exp_either[r] = 1'b0;
		if (fwd) begin
			exp_data[r] = d;
			exp_src[r] = lsq_types_pkg::SRC_FWD;
		end else begin
			exp_data[r] = mem_m[ld_addr_i];
			exp_src[r] = present_m[ld_addr_i] ? lsq_types_pkg::SRC_HIT : lsq_types_pkg::SRC_FILL;
			// an earlier miss may or may not have filled by now
			exp_either[r] = !present_m[ld_addr_i] && touched_m[ld_addr_i];
			touched_m[ld_addr_i] = 1'b1;
		end
		outstanding++;
		ld_pend = 1'b0;
	endtask

	// ********************
	// one clock of stimulus
	// ********************
	task automatic run_cycle(input bit want_disp, input bit want_exec, input bit want_ret,
		input bit want_ld);
		int cnt;
		int slot;
		int off;
		@(negedge clk);
		cyc++;
		collect_result();
		cnt = m_tail - m_head;
		// a waiting load at head must not see the queue turn full
		disp_valid_i = want_disp && !(ld_pend && ld_pos_abs == m_head && cnt == SQD - 1);
		st_valid_i = 1'b0;
		if (want_exec && cnt > 0) begin
			slot = (m_head + rand_below(cnt)) % SQD;
			if (!m_exec[slot]) begin
				st_valid_i = 1'b1;
				st_idx_i = SQ_IDX_W'(slot);
				st_addr_i = AW'(rand_below(16));
				st_data_i = $random(seed);
			end
		end
		retire_i = want_ret && cnt > 0 && m_exec[m_head % SQD] && !(ld_pend && m_head >= ld_pos_abs);
		if (!ld_pend)
			ld_valid_i = 1'b0;
		if (want_ld && !ld_pend && !exp_vld[next_rob]) begin
			off = (cnt == SQD) ? cnt : rand_below(cnt + 1);
			ld_pend = 1'b1;
			ld_pos_abs = m_head + off;
			ld_valid_i = 1'b1;
			ld_addr_i = (rand_below(2) == 0) ? AW'(rand_below(16)) : AW'(rand_below(MEM_WORDS));
			ld_sq_pos_i = SQ_IDX_W'(ld_pos_abs % SQD);
			ld_rob_idx_i = RW'(next_rob);
			ld_tag_i = TW'($random(seed));
			next_rob = (next_rob + 1) % ROBS;
		end
		#1;
		check_flag("disp_ready", cnt < SQD, disp_ready_o);
		check_idx("disp_idx", SQ_IDX_W'(m_tail % SQD), disp_idx_o);
		if (ld_valid_i && ld_ready_o)
			accept_load();
		if (disp_valid_i && cnt < SQD) begin
			m_exec[m_tail % SQD] = 1'b0;
			m_tail++;
		end
		if (st_valid_i) begin
			m_exec[st_idx_i] = 1'b1;
			m_addr[st_idx_i] = st_addr_i;
			m_data[st_idx_i] = st_data_i;
		end
		if (retire_i) begin
			slot = m_head % SQD;
			mem_m[m_addr[slot]] = m_data[slot];
			present_m[m_addr[slot]] = 1'b1;
			m_exec[slot] = 1'b0;
			m_head++;
		end
	endtask

	initial begin
		seed = 32'hea9b_4fb2;
		last_fill_cyc = -1;
		rst = 1'b1;
		disp_valid_i = 1'b0;
		st_valid_i = 1'b0;
		st_idx_i = '0;
		st_addr_i = '0;
		st_data_i = '0;
		retire_i = 1'b0;
		ld_valid_i = 1'b0;
		ld_addr_i = '0;
		ld_sq_pos_i = '0;
		ld_rob_idx_i = '0;
		ld_tag_i = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		#1;
		start_test("reset");
		check_flag("res_valid", 1'b0, res_valid_o);
		check_flag("disp_ready", 1'b1, disp_ready_o);
		check_flag("ld_ready", 1'b1, ld_ready_o);
		finish_test();

		start_test("sq_full");
		repeat (SQD) run_cycle(1'b1, 1'b0, 1'b0, 1'b0);
		run_cycle(1'b0, 1'b0, 1'b0, 1'b0);
		check_flag("full_ready", 1'b0, disp_ready_o);
		for (int k = 0; k < SQD; k++) begin
			while (!m_exec[(m_head + k) % SQD])
				run_cycle(1'b0, 1'b1, 1'b0, 1'b0);
		end
		run_cycle(1'b0, 1'b0, 1'b1, 1'b0);
		run_cycle(1'b0, 1'b0, 1'b0, 1'b0);
		check_flag("freed_ready", 1'b1, disp_ready_o);
		finish_test();

		start_test("random_traffic");
		repeat (NUM_CYCLES)
			run_cycle(rand_below(2) == 0, rand_below(3) != 0, rand_below(2) == 0, rand_below(2) == 0);
		finish_test();

		// remaining stores execute and retire so the last load can issue
		start_test("drain");
		while (ld_pend || outstanding != 0)
			run_cycle(1'b0, 1'b1, 1'b1, 1'b0);
		finish_test();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== lsq_top.f ====
rtl/lsq_cfg_pkg.sv
rtl/lsq_types_pkg.sv
rtl/store_queue.sv
rtl/load_queue.sv
rtl/miss_unit.sv
rtl/lsq_top.sv
testbench/lsq_checker.sv
testbench/lsq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsq_tb -Mdir obj_dir -o lsq_sim -f lsq_top.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/lsq_sim)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
